/* Makefile */
VERILATOR  ?= verilator
TOP        ?= alu6502_tb
FILELIST   ?= alu6502.f
BUILD_DIR  ?= obj_dir
EXE        ?= Valu6502_tb
LOG        ?= sim.log
PASS_TEXT  ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(EXE)
	./$(BUILD_DIR)/$(EXE) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu import alu6502_pkg::*; (
    alu_ctrl_if.alu_mp        ctrl,
    input  logic [DATA_W-1:0] db_in,      // data bus operand
    input  logic [DATA_W-1:0] adl_in,     // address low
    input  logic [DATA_W-1:0] sb_in,      // special bus carrying acc
    input  status_t           status,     // only c is used
    output logic [DATA_W-1:0] alu_out,
    output logic              carry_out,
    output logic              overflow
);

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              cin;
    logic [DATA_W:0]   sum;               // sum plus carry out

    // input bus selection
    always_comb begin
        b = '0;
        if (ctrl.ldb_inv_db) begin
            b = ~db_in;
        end else if (ctrl.ldb_db) begin
            b = db_in;
        end else if (ctrl.ldb_adl) begin
            b = adl_in;
        end

        a = '0;
        if (ctrl.lda_sb) begin
            a = sb_in;
        end else if (ctrl.lda_zero) begin
            a = '0;
        end
    end

    always_comb begin
        case (ctrl.cin_sel)
            CIN_ONE:  cin = 1'b1;
            CIN_FLAG: cin = status.c;
            default:  cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, cin};

    always_comb begin
        alu_out   = '0;                   // idle outputs are zero
        carry_out = 1'b0;
        overflow  = 1'b0;

        if (ctrl.e_sum) begin
            alu_out   = sum[DATA_W-1:0];
            carry_out = sum[DATA_W];
            // same-sign operands whose result flips sign
            overflow  = (a[SIGN_BIT] == b[SIGN_BIT]) &&
                        (sum[SIGN_BIT] != a[SIGN_BIT]);
        end else if (ctrl.e_and) begin
            alu_out = a & b;
        end else if (ctrl.e_eor) begin
            alu_out = a ^ b;
        end else if (ctrl.e_or) begin
            alu_out = a | b;
        end else if (ctrl.e_shiftr) begin
            alu_out   = {cin, a[DATA_W-1:1]};   // cin fills the msb
            carry_out = a[0];
        end
    end

endmodule

/* alu6502.f */
alu6502_pkg.sv
alu_ctrl_if.sv
op_decode.sv
alu.sv
status_writeback.sv
alu6502_top.sv
alu6502_assert.sv
alu6502_tb.sv

/* alu6502_assert.sv */
`timescale 1ns/1ps

module alu6502_assert import alu6502_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              op_valid,
    input logic              result_valid,
    input logic [DATA_W-1:0] acc,
    input logic              ctrl_valid,     // decoded strobe
    input logic              e_sum,
    input logic              e_and,
    input logic              e_eor,
    input logic              e_or,
    input logic              e_shiftr
);

    a_latency: assert property (@(posedge clk) disable iff (reset)
        op_valid |-> ##2 result_valid)
        else $error("result_valid missing two cycles after op_valid");

    // decode never enables two ALU functions at once
    a_one_func: assert property (@(posedge clk) disable iff (reset)
        ctrl_valid |-> $onehot0({e_sum, e_and, e_eor, e_or, e_shiftr}))
        else $error("more than one ALU function strobe active");

    a_quiet_reset: assert property (@(posedge clk)
        reset ##1 reset |-> !result_valid)
        else $error("result_valid high while reset is held");

    a_acc_known: assert property (@(posedge clk)
        !reset |-> !$isunknown(acc))
        else $error("acc has unknown bits after reset");

endmodule

bind alu6502_top alu6502_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .op_valid     (op_valid),
    .result_valid (result_valid),
    .acc          (acc),
    .ctrl_valid   (u_ctrl.valid),
    .e_sum        (u_ctrl.e_sum),
    .e_and        (u_ctrl.e_and),
    .e_eor        (u_ctrl.e_eor),
    .e_or         (u_ctrl.e_or),
    .e_shiftr     (u_ctrl.e_shiftr)
);

/* alu6502_pkg.sv */
package alu6502_pkg;

    localparam int DATA_W   = 8;            // datapath width
    localparam int SIGN_BIT = DATA_W - 1;   // msb used for N and signed overflow
    localparam int OP_W     = 4;            // opcode field width
    localparam int CIN_W    = 2;            // carry-in select width

    // ALU opcodes seen at the core boundary
    typedef enum logic [OP_W-1:0] {
        OP_ADC = 4'h0,                      // add with carry
        OP_SBC = 4'h1,                      // subtract with borrow
        OP_AND = 4'h2,
        OP_ORA = 4'h3,
        OP_EOR = 4'h4,
        OP_LSR = 4'h5,                      // shift right, zero into msb
        OP_ROR = 4'h6,                      // rotate right through carry
        OP_LDA = 4'h7,                      // load acc via 0 + operand
        OP_IDX = 4'h8,                      // index add into ea byte
        OP_CLC = 4'h9,
        OP_SEC = 4'ha
    } alu_op_t;

    // where the ALU carry-in comes from
    typedef enum logic [CIN_W-1:0] {
        CIN_ZERO = 2'd0,
        CIN_ONE  = 2'd1,
        CIN_FLAG = 2'd2                     // registered C flag
    } cin_sel_t;

    // processor status subset in 6502 P register order
    typedef struct packed {
        logic n;                            // negative
        logic v;                            // signed overflow
        logic z;                            // zero
        logic c;                            // carry
    } status_t;

endpackage

/* alu6502_tb.sv */
`timescale 1ns/1ps

module alu6502_tb import alu6502_pkg::*; ();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 3;
    localparam logic [31:0] SEED         = 32'hc332_d758;

    logic              clk;
    logic              reset;
    logic              op_valid;
    alu_op_t           opcode;
    logic [DATA_W-1:0] operand;
    logic [DATA_W-1:0] addr_low;
    logic              result_valid;
    logic [DATA_W-1:0] acc;
    logic              flag_n;
    logic              flag_v;
    logic              flag_z;
    logic              flag_c;
    logic [DATA_W-1:0] ea_out;
    logic              page_cross;

    alu_op_t           tbl_op[$];       // stimulus table with one entry per cycle
    logic [DATA_W-1:0] tbl_opd[$];
    logic [DATA_W-1:0] tbl_adl[$];
    string             tbl_name[$];

    logic [DATA_W-1:0] m_acc;           // reference model state
    status_t           m_st;
    logic [DATA_W-1:0] m_ea;
    logic              m_pc;

    logic [DATA_W-1:0] exp_acc[$];      // results waiting for result_valid
    status_t           exp_st[$];
    logic [DATA_W-1:0] exp_ea[$];
    logic              exp_pc[$];
    string             exp_name[$];
    int                exp_due[$];

    int cyc;
    int n_directed;
    bit table_ready;

    alu6502_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .opcode       (opcode),
        .operand      (operand),
        .addr_low     (addr_low),
        .result_valid (result_valid),
        .acc          (acc),
        .flag_n       (flag_n),
        .flag_v       (flag_v),
        .flag_z       (flag_z),
        .flag_c       (flag_c),
        .ea_out       (ea_out),
        .page_cross   (page_cross)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_stop();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input string what,
                              input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected 0x%02h, actual 0x%02h", name, what, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("[ERROR] %s nvzc: expected %b, actual %b", name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %b, actual %b", name, what, exp, act);
            fail_stop();
        end
    endtask

    task automatic add_entry(input alu_op_t op, input logic [DATA_W-1:0] opd,
                             input logic [DATA_W-1:0] adl, input string name);
        tbl_op.push_back(op);
        tbl_opd.push_back(opd);
        tbl_adl.push_back(adl);
        tbl_name.push_back(name);
    endtask

    task automatic build_directed();
        add_entry(OP_SEC, 8'h00, 8'h00, "sec");
        add_entry(OP_CLC, 8'h00, 8'h00, "clc");
        add_entry(OP_LDA, 8'h7f, 8'h00, "lda_7f");
        add_entry(OP_ADC, 8'h01, 8'h00, "adc_7f_01");       // signed overflow to 0x80
        add_entry(OP_LDA, 8'h80, 8'h00, "lda_80");
        add_entry(OP_SEC, 8'h00, 8'h00, "sec_before_sbc");
        add_entry(OP_SBC, 8'h01, 8'h00, "sbc_80_01");       // 0x80 - 1 overflows
        add_entry(OP_LDA, 8'hff, 8'h00, "lda_ff");
        add_entry(OP_CLC, 8'h00, 8'h00, "clc_before_adc");
        add_entry(OP_ADC, 8'h01, 8'h00, "adc_ff_01");       // wraps to zero and sets C
        add_entry(OP_ADC, 8'h10, 8'h00, "adc_carry_chain"); // uses C from previous op
        add_entry(OP_SBC, 8'h20, 8'h00, "sbc_borrow");
        add_entry(OP_LDA, 8'h3c, 8'h00, "lda_3c");
        add_entry(OP_AND, 8'h0f, 8'h00, "and_0f");
        add_entry(OP_ORA, 8'hf0, 8'h00, "ora_f0");
        add_entry(OP_EOR, 8'hff, 8'h00, "eor_ff");
        add_entry(OP_LDA, 8'h81, 8'h00, "lda_81");
        add_entry(OP_LSR, 8'h00, 8'h00, "lsr_81");
        add_entry(OP_ROR, 8'h00, 8'h00, "ror_c1");          // old C into bit 7
        add_entry(OP_ROR, 8'h00, 8'h00, "ror_c0");
        add_entry(OP_SEC, 8'h00, 8'h00, "sec_before_ror");
        add_entry(OP_LDA, 8'h02, 8'h00, "lda_02");
        add_entry(OP_ROR, 8'h00, 8'h00, "ror_02");
        add_entry(OP_LDA, 8'hf0, 8'h00, "lda_f0");
        add_entry(OP_IDX, 8'h00, 8'h20, "idx_f0_20");       // crosses the page
        add_entry(OP_IDX, 8'h00, 8'h05, "idx_f0_05");
        add_entry(OP_LDA, 8'h00, 8'h00, "lda_00");
    endtask

    // operation table rules applied at issue time
    task automatic model_apply(input alu_op_t op, input logic [DATA_W-1:0] opd,
                               input logic [DATA_W-1:0] adl);
        logic [DATA_W-1:0] b;
        logic [DATA_W:0]   sum;
        logic              old_c;
        b     = (op == OP_SBC) ? ~opd : opd;
        old_c = m_st.c;
        case (op)
            OP_ADC, OP_SBC: begin
                sum    = {1'b0, m_acc} + {1'b0, b} + {{DATA_W{1'b0}}, old_c};
                m_st.v = (m_acc[7] == b[7]) && (sum[7] != m_acc[7]);
                m_st.c = sum[DATA_W];
                m_acc  = sum[DATA_W-1:0];
            end
            OP_AND: m_acc = m_acc & opd;
            OP_ORA: m_acc = m_acc | opd;
            OP_EOR: m_acc = m_acc ^ opd;
            OP_LSR: begin
                m_st.c = m_acc[0];
                m_acc  = m_acc >> 1;
            end
            OP_ROR: begin
                m_st.c = m_acc[0];
                m_acc  = {old_c, m_acc[DATA_W-1:1]};
            end
            OP_LDA: m_acc = opd;
            OP_IDX: begin
                sum  = {1'b0, m_acc} + {1'b0, adl};
                m_ea = sum[DATA_W-1:0];
                m_pc = sum[DATA_W];                 // carry out of the low byte
            end
            OP_CLC: m_st.c = 1'b0;
            OP_SEC: m_st.c = 1'b1;
            default: ;
        endcase
        if (!(op inside {OP_IDX, OP_CLC, OP_SEC})) begin
            m_st.n = m_acc[7];
            m_st.z = (m_acc == '0);
        end
    endtask

    task automatic issue(input int k);
        op_valid = 1'b1;
        opcode   = tbl_op[k];
        model_apply(tbl_op[k], tbl_opd[k], tbl_adl[k]);
        exp_acc.push_back(m_acc);
        exp_st.push_back(m_st);
        exp_ea.push_back(m_ea);
        exp_pc.push_back(m_pc);
        exp_name.push_back(tbl_name[k]);
        exp_due.push_back(cyc + 2);                 // seen two falling edges later
    endtask

    task automatic check_results();
        if (exp_due.size() > 0 && exp_due[0] == cyc) begin
            if (result_valid !== 1'b1) begin
                $display("result_valid did not pulse for test %s", exp_name[0]);
                fail_stop();
            end
            check_byte(exp_name[0], "acc", exp_acc[0], acc);
            check_status(exp_name[0], exp_st[0], status_t'({flag_n, flag_v, flag_z, flag_c}));
            check_byte(exp_name[0], "ea_out", exp_ea[0], ea_out);
            check_bit(exp_name[0], "page_cross", exp_pc[0], page_cross);
            void'(exp_acc.pop_front());
            void'(exp_st.pop_front());
            void'(exp_ea.pop_front());
            void'(exp_pc.pop_front());
            void'(exp_name.pop_front());
            void'(exp_due.pop_front());
        end else if (result_valid !== 1'b0) begin
            $display("result_valid pulsed with no operation due at cycle %0d", cyc);
            fail_stop();
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          total;
        reset    = 1'b1;
        op_valid = 1'b0;
        opcode   = OP_LDA;
        operand  = '0;
        addr_low = '0;
        cyc      = 0;
        m_acc    = '0;
        m_st     = '0;
        m_ea     = '0;
        m_pc     = 1'b0;
        void'($urandom(SEED));
        build_directed();
        n_directed = tbl_op.size();
        for (int k = 0; k < n_directed; k++) begin
            rnd = $urandom();                       // same opcodes with random data
            add_entry(tbl_op[k], rnd[7:0], rnd[15:8], $sformatf("rnd_%0d_%s", k, tbl_name[k]));
        end
        total       = tbl_op.size();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_byte("reset", "acc", '0, acc);
        check_status("reset", '0, status_t'({flag_n, flag_v, flag_z, flag_c}));
        check_byte("reset", "ea_out", '0, ea_out);
        check_bit("reset", "page_cross", 1'b0, page_cross);
        check_bit("reset", "result_valid", 1'b0, result_valid);
        reset = 1'b0;

        for (int k = 0; k <= total; k++) begin
            @(negedge clk);
            cyc++;
            check_results();
            // the ALU reads the data buses one cycle after the opcode
            if (k > 0) begin
                operand  = tbl_opd[k-1];
                addr_low = tbl_adl[k-1];
            end
            if (k < total) begin
                issue(k);
            end else begin
                op_valid = 1'b0;
            end
        end
        repeat (2) begin
            @(negedge clk);
            cyc++;
            check_results();
        end

        if (exp_due.size() != 0) begin
            $display("%0d results never arrived, first is %s", exp_due.size(), exp_name[0]);
            fail_stop();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    // two cycles per table entry plus reset and drain margin
    initial begin
        wait (table_ready);
        #((tbl_op.size() * 2 + 20) * CLK_PERIOD);
        $display("timeout after %0d ns without reaching the end of the tests", $time);
        fail_stop();
    end

endmodule

/* alu6502_top.sv */
`timescale 1ns/1ps

module alu6502_top import alu6502_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              op_valid,
    input  alu_op_t           opcode,
    input  logic [DATA_W-1:0] operand,
    input  logic [DATA_W-1:0] addr_low,
    output logic              result_valid,
    output logic [DATA_W-1:0] acc,
    output logic              flag_n,
    output logic              flag_v,
    output logic              flag_z,
    output logic              flag_c,
    output logic [DATA_W-1:0] ea_out,
    output logic              page_cross
);

    alu_ctrl_if u_ctrl ();

    logic [DATA_W-1:0] alu_out;
    logic              carry_out;
    logic              overflow;
    status_t           status;

    op_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .opcode   (opcode),
        .ctrl     (u_ctrl.decode_mp)
    );

    alu u_alu (
        .ctrl      (u_ctrl.alu_mp),
        .db_in     (operand),
        .adl_in    (addr_low),
        .sb_in     (acc),           // acc feeds back on the special bus
        .status    (status),        // carry seen by the next op
        .alu_out   (alu_out),
        .carry_out (carry_out),
        .overflow  (overflow)
    );

    status_writeback u_wb (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (u_ctrl.wb_mp),
        .alu_out      (alu_out),
        .carry_out    (carry_out),
        .overflow     (overflow),
        .acc          (acc),
        .status       (status),
        .ea_out       (ea_out),
        .page_cross   (page_cross),
        .result_valid (result_valid)
    );

    assign flag_n = status.n;
    assign flag_v = status.v;
    assign flag_z = status.z;
    assign flag_c = status.c;

endmodule

/* alu_ctrl_if.sv */
`timescale 1ns/1ps

interface alu_ctrl_if import alu6502_pkg::*; ();

    logic     valid;        // one strobe per decoded op
    logic     ldb_inv_db;   // ~db on b
    logic     ldb_db;       // db on b
    logic     ldb_adl;      // adl on b
    logic     lda_sb;       // sb on a
    logic     lda_zero;     // zeroes on a
    cin_sel_t cin_sel;
    logic     e_sum;
    logic     e_and;
    logic     e_eor;
    logic     e_or;
    logic     e_shiftr;
    logic     wr_acc;
    logic     wr_nz;
    logic     wr_c;
    logic     wr_v;
    logic     wr_ea;
    logic     c_value;      // constant carry for CLC/SEC

    modport decode_mp (
        output valid, ldb_inv_db, ldb_db, ldb_adl, lda_sb, lda_zero, cin_sel,
               e_sum, e_and, e_eor, e_or, e_shiftr,
               wr_acc, wr_nz, wr_c, wr_v, wr_ea, c_value
    );

    modport alu_mp (
        input ldb_inv_db, ldb_db, ldb_adl, lda_sb, lda_zero, cin_sel,
              e_sum, e_and, e_eor, e_or, e_shiftr
    );

    modport wb_mp (
        input valid, wr_acc, wr_nz, wr_c, wr_v, wr_ea, c_value
    );

endinterface

/* op_decode.sv */
`timescale 1ns/1ps

module op_decode import alu6502_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          op_valid,      // one op per strobe
    input  alu_op_t       opcode,
    alu_ctrl_if.decode_mp ctrl
);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.valid      <= 1'b0;
            ctrl.ldb_inv_db <= 1'b0;
            ctrl.ldb_db     <= 1'b0;
            ctrl.ldb_adl    <= 1'b0;
            ctrl.lda_sb     <= 1'b0;
            ctrl.lda_zero   <= 1'b0;
            ctrl.cin_sel    <= CIN_ZERO;
            ctrl.e_sum      <= 1'b0;
            ctrl.e_and      <= 1'b0;
            ctrl.e_eor      <= 1'b0;
            ctrl.e_or       <= 1'b0;
            ctrl.e_shiftr   <= 1'b0;
            ctrl.wr_acc     <= 1'b0;
            ctrl.wr_nz      <= 1'b0;
            ctrl.wr_c       <= 1'b0;
            ctrl.wr_v       <= 1'b0;
            ctrl.wr_ea      <= 1'b0;
            ctrl.c_value    <= 1'b0;
        end else begin
            // idle cycle unless overridden below
            ctrl.valid      <= op_valid;
            ctrl.ldb_inv_db <= 1'b0;
            ctrl.ldb_db     <= 1'b0;
            ctrl.ldb_adl    <= 1'b0;
            ctrl.lda_sb     <= 1'b0;
            ctrl.lda_zero   <= 1'b0;
            ctrl.cin_sel    <= CIN_ZERO;
            ctrl.e_sum      <= 1'b0;
            ctrl.e_and      <= 1'b0;
            ctrl.e_eor      <= 1'b0;
            ctrl.e_or       <= 1'b0;
            ctrl.e_shiftr   <= 1'b0;
            ctrl.wr_acc     <= 1'b0;
            ctrl.wr_nz      <= 1'b0;
            ctrl.wr_c       <= 1'b0;
            ctrl.wr_v       <= 1'b0;
            ctrl.wr_ea      <= 1'b0;
            ctrl.c_value    <= 1'b0;

            if (op_valid) begin
                case (opcode)
                    OP_ADC, OP_SBC: begin
                        ctrl.lda_sb     <= 1'b1;
                        ctrl.ldb_db     <= (opcode == OP_ADC);
                        ctrl.ldb_inv_db <= (opcode == OP_SBC);   // a + ~m + c
                        ctrl.cin_sel    <= CIN_FLAG;
                        ctrl.e_sum      <= 1'b1;
                        ctrl.wr_acc     <= 1'b1;
                        ctrl.wr_nz      <= 1'b1;
                        ctrl.wr_c       <= 1'b1;
                        ctrl.wr_v       <= 1'b1;
                    end
                    OP_AND, OP_ORA, OP_EOR: begin
                        ctrl.lda_sb <= 1'b1;
                        ctrl.ldb_db <= 1'b1;
                        ctrl.e_and  <= (opcode == OP_AND);
                        ctrl.e_or   <= (opcode == OP_ORA);
                        ctrl.e_eor  <= (opcode == OP_EOR);
                        ctrl.wr_acc <= 1'b1;
                        ctrl.wr_nz  <= 1'b1;
                    end
                    OP_LSR, OP_ROR: begin
                        ctrl.lda_sb   <= 1'b1;
                        ctrl.cin_sel  <= (opcode == OP_ROR) ? CIN_FLAG : CIN_ZERO;
                        ctrl.e_shiftr <= 1'b1;
                        ctrl.wr_acc   <= 1'b1;
                        ctrl.wr_nz    <= 1'b1;
                        ctrl.wr_c     <= 1'b1;
                    end
                    OP_LDA: begin
                        ctrl.lda_zero <= 1'b1;       // 0 + operand
                        ctrl.ldb_db   <= 1'b1;
                        ctrl.e_sum    <= 1'b1;
                        ctrl.wr_acc   <= 1'b1;
                        ctrl.wr_nz    <= 1'b1;
                    end
                    OP_IDX: begin
                        ctrl.lda_sb  <= 1'b1;
                        ctrl.ldb_adl <= 1'b1;
                        ctrl.e_sum   <= 1'b1;
                        ctrl.wr_ea   <= 1'b1;        // acc and flags untouched
                    end
                    OP_CLC, OP_SEC: begin
                        ctrl.wr_c    <= 1'b1;
                        ctrl.c_value <= (opcode == OP_SEC);
                    end
                    default: ;                       // unknown op retires as a no-op
                endcase
            end
        end
    end

endmodule

/* status_writeback.sv */
`timescale 1ns/1ps

module status_writeback import alu6502_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    alu_ctrl_if.wb_mp         ctrl,
    input  logic [DATA_W-1:0] alu_out,
    input  logic              carry_out,
    input  logic              overflow,
    output logic [DATA_W-1:0] acc,
    output status_t           status,
    output logic [DATA_W-1:0] ea_out,       // effective address byte
    output logic              page_cross,
    output logic              result_valid
);

    logic next_c;

    // CLC/SEC have no function strobe so carry_out is zero there
    assign next_c = carry_out | ctrl.c_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= ctrl.valid;     // one cycle behind decode
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (ctrl.valid && ctrl.wr_acc) begin
            acc <= alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (ctrl.valid) begin
            if (ctrl.wr_nz) begin
                status.n <= alu_out[SIGN_BIT];
                status.z <= (alu_out == '0);
            end
            if (ctrl.wr_c) begin
                status.c <= next_c;
            end
            if (ctrl.wr_v) begin
                status.v <= overflow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ea_out     <= '0;
            page_cross <= 1'b0;
        end else if (ctrl.valid && ctrl.wr_ea) begin
            ea_out     <= alu_out;
            page_cross <= carry_out;        // carry out of the low byte
        end
    end

endmodule
